// File: rtl/tankPeriphPkg.sv
`default_nettype none

package tankPeriphPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;

    // AHB transfer type and size encodings
    typedef enum logic [1:0] {
        TransIdle   = 2'b00,
        TransBusy   = 2'b01,
        TransNonseq = 2'b10,
        TransSeq    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        SizeByte = 3'b000,
        SizeHalf = 3'b001,
        SizeWord = 3'b010
    } hsize_e;

    // Mapped values of the top address nibble
    typedef enum logic [3:0] {
        RegionRam = 4'h0,
        RegionApb = 4'h4
    } region_e;

    // One bus address seen as a RAM word address or as APB slot/register
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [15:0] reserved;
            logic [9:0]  wordIndex;
            logic [1:0]  byteOffset;
        } ram;
        struct packed {
            logic [3:0]  region;
            logic [11:0] reserved;
            logic [3:0]  slot;
            logic [11:0] regOffset;
        } apb;
    } socAddr_u;

    // Keypad slot and its registers
    localparam logic [3:0]  KeypadSlot      = 4'd0;
    localparam logic [11:0] KeyStateOffset  = 12'h000;
    localparam logic [11:0] IntStatusOffset = 12'h004;

endpackage

`default_nettype wire

// File: rtl/ahbDecode.sv
`default_nettype none

module ahbDecode
    import tankPeriphPkg::*;
#(
    parameter int RamWords = 1024
) (
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire logic [AddrWidth-1:0] haddr,
    input  wire htrans_e              htrans,
    input  wire logic                 hwrite,
    input  wire hsize_e               hsize,
    input  wire logic                 hready,
    output logic                      ramSel,
    output logic                      apbSel,
    output logic                      errSel,
    output socAddr_u                  dataAddr,
    output hsize_e                    dataSize,
    output logic                      dataWrite
);

    socAddr_u addrView;
    logic     accept;
    logic     ramHit;
    logic     apbHit;

    assign addrView = haddr;
    assign accept   = hready && (htrans == TransNonseq);

    // Region decode on the live address phase
    assign ramHit = (addrView.ram.region == RegionRam)
                 && (int'(addrView.ram.wordIndex) < RamWords);
    assign apbHit = (addrView.apb.region == RegionApb);

    // ----------------------------------------------------------
    // Data-phase selects
    // ----------------------------------------------------------
    // Updated only when the current data phase ends, so a stalled
    // transfer keeps its select
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            ramSel <= 1'b0;
            apbSel <= 1'b0;
            errSel <= 1'b0;
        end else if (hready) begin
            ramSel <= accept && ramHit;
            apbSel <= accept && apbHit;
            errSel <= accept && !ramHit && !apbHit;
        end
    end

    // Attributes of the accepted transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            dataAddr  <= addrView;
            dataSize  <= hsize;
            dataWrite <= hwrite;
        end
    end

endmodule

`default_nettype wire

// File: rtl/blockRam.sv
`default_nettype none

module blockRam
    import tankPeriphPkg::*;
#(
    parameter int RamWords = 1024
) (
    input  wire logic                 clk,
    input  wire logic                 ramSel,
    input  wire socAddr_u             dataAddr,
    input  wire hsize_e               dataSize,
    input  wire logic                 dataWrite,
    input  wire logic [DataWidth-1:0] hwdata,
    input  wire logic [9:0]           readIndex,
    output logic      [DataWidth-1:0] ramRdata
);

    localparam int Lanes = DataWidth / 8;

    logic [DataWidth-1:0] mem [RamWords];
    logic [Lanes-1:0]     laneEn;
    logic [9:0]           writeIndex;
    logic                 writeEn;
    logic                 sameWord;

    assign writeIndex = dataAddr.ram.wordIndex;
    assign writeEn    = ramSel && dataWrite;
    assign sameWord   = writeEn && (writeIndex == readIndex);

    // Byte lanes from size and low address bits
    always_comb begin
        case (dataSize)
            SizeByte: laneEn = 4'b0001 << dataAddr.ram.byteOffset;
            SizeHalf: laneEn = dataAddr.ram.byteOffset[1] ? 4'b1100 : 4'b0011;
            default:  laneEn = {Lanes{1'b1}};
        endcase
    end

    // ----------------------------------------------------------
    // Write port, data phase
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int b = 0; b < Lanes; b++) begin
            if (writeEn && laneEn[b]) begin
                mem[writeIndex][b*8 +: 8] <= hwdata[b*8 +: 8];
            end
        end
    end

    // ----------------------------------------------------------
    // Read port, address phase
    // ----------------------------------------------------------
    // A write finishing on the same edge is forwarded lane by lane,
    // so back-to-back write then read sees the new data
    always_ff @(posedge clk) begin
        for (int b = 0; b < Lanes; b++) begin
            if (sameWord && laneEn[b]) begin
                ramRdata[b*8 +: 8] <= hwdata[b*8 +: 8];
            end else begin
                ramRdata[b*8 +: 8] <= mem[readIndex][b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/apbBridge.sv
`default_nettype none

module apbBridge
    import tankPeriphPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire logic                 apbSel,
    input  wire socAddr_u             dataAddr,
    input  wire logic                 dataWrite,
    input  wire logic [DataWidth-1:0] hwdata,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic      [11:0]          paddr,
    output logic      [DataWidth-1:0] pwdata,
    input  wire logic [DataWidth-1:0] prdata,
    output logic      [DataWidth-1:0] bridgeRdata,
    output logic                      bridgeReady,
    output logic                      bridgeErr
);

    // Idle doubles as the setup phase when a fresh select arrives
    localparam logic [1:0] StIdle   = 2'd0;
    localparam logic [1:0] StAccess = 2'd1;
    localparam logic [1:0] StDone   = 2'd2;

    logic [1:0] state;
    logic       slotHit;
    logic       start;

    assign slotHit = (dataAddr.apb.slot == KeypadSlot);
    assign start   = apbSel && (state == StIdle);

    // ----------------------------------------------------------
    // APB side
    // ----------------------------------------------------------
    // Setup straight from the registered select, access one cycle later
    assign psel    = (start && slotHit) || (state == StAccess);
    assign penable = (state == StAccess);
    assign pwrite  = dataWrite;
    assign paddr   = dataAddr.apb.regOffset;
    assign pwdata  = hwdata;

    // ----------------------------------------------------------
    // AHB side
    // ----------------------------------------------------------
    // Empty slot gives no APB cycle and an error at once
    assign bridgeErr   = start && !slotHit;
    assign bridgeReady = (state == StDone);

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle: begin
                    if (apbSel) begin
                        state <= slotHit ? StAccess : StDone;
                    end
                end
                StAccess: state <= StDone;
                default:  state <= StIdle;
            endcase
        end
    end

    // Read data held for the completing cycle
    always_ff @(posedge clk) begin
        if (state == StAccess) begin
            bridgeRdata <= prdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/keypadScanner.sv
`default_nettype none

module keypadScanner
    import tankPeriphPkg::*;
#(
    parameter int ScanDivide = 16
) (
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire logic [3:0]           col,
    output logic      [3:0]           row,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire logic [11:0]          paddr,
    input  wire logic [DataWidth-1:0] pwdata,
    output logic      [DataWidth-1:0] prdata,
    output logic                      keyInt
);

    localparam int DivBits = (ScanDivide > 1) ? $clog2(ScanDivide) : 1;

    logic [DivBits-1:0] divCount;
    logic [1:0]         rowIdx;
    logic               rowEnd;
    logic [3:0]         colMeta;
    logic [3:0]         colSync;
    logic [3:0]         colPressed;
    logic [3:0]         rowKeys;
    logic [15:0]        keyState;
    logic               newPress;
    logic               intStatus;
    logic               clearWrite;

    // ----------------------------------------------------------
    // Row scan
    // ----------------------------------------------------------
    assign rowEnd = (divCount == DivBits'(ScanDivide - 1));
    assign row    = ~(4'b0001 << rowIdx);

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            divCount <= '0;
            rowIdx   <= 2'd0;
        end else if (rowEnd) begin
            divCount <= '0;
            rowIdx   <= rowIdx + 2'd1;
        end else begin
            divCount <= divCount + DivBits'(1);
        end
    end

    // Keypad pins are asynchronous
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            colMeta <= 4'hF;
            colSync <= 4'hF;
        end else begin
            colMeta <= col;
            colSync <= colMeta;
        end
    end

    // ----------------------------------------------------------
    // Key state and interrupt
    // ----------------------------------------------------------
    // Columns are active low, bit index is row * 4 + column
    assign colPressed = ~colSync;
    assign rowKeys    = keyState[{rowIdx, 2'b00} +: 4];
    assign newPress   = rowEnd && (|(colPressed & ~rowKeys));

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            keyState <= '0;
        end else if (rowEnd) begin
            keyState[{rowIdx, 2'b00} +: 4] <= colPressed;
        end
    end

    assign clearWrite = psel && penable && pwrite
                     && (paddr == IntStatusOffset) && pwdata[0];

    // A press in the same cycle as the clear wins
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            intStatus <= 1'b0;
        end else if (newPress) begin
            intStatus <= 1'b1;
        end else if (clearWrite) begin
            intStatus <= 1'b0;
        end
    end

    assign keyInt = intStatus;

    // Register read mux
    always_comb begin
        case (paddr)
            KeyStateOffset:  prdata = {{(DataWidth-16){1'b0}}, keyState};
            IntStatusOffset: prdata = {{(DataWidth-1){1'b0}}, intStatus};
            default:         prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/responseMerge.sv
`default_nettype none

module responseMerge
    import tankPeriphPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire logic                 ramSel,
    input  wire logic                 apbSel,
    input  wire logic                 errSel,
    input  wire logic [DataWidth-1:0] ramRdata,
    input  wire logic [DataWidth-1:0] bridgeRdata,
    input  wire logic                 bridgeReady,
    input  wire logic                 bridgeErr,
    output logic      [DataWidth-1:0] hrdata,
    output logic                      hready,
    output logic                      hresp
);

    logic errFirst;
    logic errSecond;

    // ----------------------------------------------------------
    // Two-cycle ERROR response
    // ----------------------------------------------------------
    assign errFirst = (errSel || bridgeErr) && !errSecond;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            errSecond <= 1'b0;
        end else begin
            errSecond <= errFirst;
        end
    end

    assign hresp = errFirst || errSecond;

    // Only the bridge stalls, the RAM never does
    always_comb begin
        if (errFirst) begin
            hready = 1'b0;
        end else if (errSecond) begin
            hready = 1'b1;
        end else if (apbSel) begin
            hready = bridgeReady;
        end else begin
            hready = 1'b1;
        end
    end

    always_comb begin
        if (apbSel) begin
            hrdata = bridgeRdata;
        end else if (ramSel) begin
            hrdata = ramRdata;
        end else begin
            hrdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tankPeriphTop.sv
`default_nettype none

module tankPeriphTop
    import tankPeriphPkg::*;
#(
    parameter int RamWords   = 1024,
    parameter int ScanDivide = 16
) (
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire logic [AddrWidth-1:0] haddr,
    input  wire htrans_e              htrans,
    input  wire logic                 hwrite,
    input  wire hsize_e               hsize,
    input  wire logic [DataWidth-1:0] hwdata,
    output logic      [DataWidth-1:0] hrdata,
    output logic                      hready,
    output logic                      hresp,
    input  wire logic [3:0]           col,
    output logic      [3:0]           row,
    output logic                      keyInt
);

    socAddr_u             liveAddr;
    logic                 ramSel;
    logic                 apbSel;
    logic                 errSel;
    socAddr_u             dataAddr;
    hsize_e               dataSize;
    logic                 dataWrite;
    logic [DataWidth-1:0] ramRdata;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [11:0]          paddr;
    logic [DataWidth-1:0] pwdata;
    logic [DataWidth-1:0] prdata;
    logic [DataWidth-1:0] bridgeRdata;
    logic                 bridgeReady;
    logic                 bridgeErr;

    assign liveAddr = haddr;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    ahbDecode #(
        .RamWords (RamWords)
    ) i_ahbDecode (
        .clk       (clk),
        .RSTn      (RSTn),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hready    (hready),
        .ramSel    (ramSel),
        .apbSel    (apbSel),
        .errSel    (errSel),
        .dataAddr  (dataAddr),
        .dataSize  (dataSize),
        .dataWrite (dataWrite)
    );

    // ----------------------------------------------------------
    // Execute
    // ----------------------------------------------------------
    blockRam #(
        .RamWords (RamWords)
    ) i_blockRam (
        .clk       (clk),
        .ramSel    (ramSel),
        .dataAddr  (dataAddr),
        .dataSize  (dataSize),
        .dataWrite (dataWrite),
        .hwdata    (hwdata),
        .readIndex (liveAddr.ram.wordIndex),
        .ramRdata  (ramRdata)
    );

    apbBridge i_apbBridge (
        .clk         (clk),
        .RSTn        (RSTn),
        .apbSel      (apbSel),
        .dataAddr    (dataAddr),
        .dataWrite   (dataWrite),
        .hwdata      (hwdata),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .bridgeRdata (bridgeRdata),
        .bridgeReady (bridgeReady),
        .bridgeErr   (bridgeErr)
    );

    keypadScanner #(
        .ScanDivide (ScanDivide)
    ) i_keypadScanner (
        .clk     (clk),
        .RSTn    (RSTn),
        .col     (col),
        .row     (row),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .keyInt  (keyInt)
    );

    // ----------------------------------------------------------
    // Result
    // ----------------------------------------------------------
    responseMerge i_responseMerge (
        .clk         (clk),
        .RSTn        (RSTn),
        .ramSel      (ramSel),
        .apbSel      (apbSel),
        .errSel      (errSel),
        .ramRdata    (ramRdata),
        .bridgeRdata (bridgeRdata),
        .bridgeReady (bridgeReady),
        .bridgeErr   (bridgeErr),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp)
    );

endmodule

`default_nettype wire

// File: bench/tbChecker.sv
`default_nettype none

module tbChecker
    import tankPeriphPkg::*;
#(
    parameter int RamWords = 1024
) (
    input  wire logic        clk,
    input  wire logic        RSTn,
    input  wire logic [31:0] haddr,
    input  wire htrans_e     htrans,
    input  wire logic        hwrite,
    input  wire hsize_e      hsize,
    input  wire logic [31:0] hwdata,
    input  wire logic [31:0] hrdata,
    input  wire logic        hready,
    input  wire logic        hresp,
    input  wire logic [3:0]  row,
    input  wire logic        keyInt,
    input  wire logic        keyDown,
    input  wire logic [3:0]  keyIdx,
    input  wire logic        intProbe,
    input  wire logic        intExpected,
    input  wire logic        testDone,
    input  int               testNum,
    input  wire logic        runDone,
    output int               errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] shadow [RamWords];
    logic        active;
    logic        resetSeen;
    logic [31:0] phaseAddr;
    logic        phaseWrite;
    hsize_e      phaseSize;
    int          phaseCycles;
    logic        errFirstSeen;
    int          checkCount;
    int          testCount;
    int          startChecks;
    int          startErrors;

    // Byte lanes touched by a transfer
    function automatic logic [31:0] laneMask(input hsize_e size, input logic [1:0] offset);
        case (size)
            SizeByte: return 32'h0000_00FF << {offset, 3'b000};
            SizeHalf: return offset[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:  return 32'hFFFF_FFFF;
        endcase
    endfunction

    // Expected response from the memory map, shadow RAM and pressed key
    // Returns 1 where an ERROR response is due
    function automatic logic refResponse(input logic [31:0] addr, output logic [31:0] data);
        data = '0;
        if (addr[31:28] == 4'h0 && int'(addr[11:2]) < RamWords) begin
            data = shadow[addr[11:2]];
            return 1'b0;
        end
        if (addr[31:28] == 4'h4) begin
            if (addr[15:12] != 4'h0) begin
                return 1'b1;
            end
            if (addr[11:0] == 12'h000 && keyDown) begin
                data = 32'h1 << keyIdx;
            end
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic string testName(input int num);
        case (num)
            1:       return "reset state";
            2:       return "word writes and reads";
            3:       return "sub-word writes";
            4:       return "error responses";
            5:       return "key press";
            6:       return "clear and release";
            default: return "unnamed";
        endcase
    endfunction

    // ----------------------------------------------------------
    // Data phase completion
    // ----------------------------------------------------------
    task automatic finishPhase();
        logic        expErr;
        logic [31:0] expData;
        logic [31:0] mask;
        int          expCycles;
        expErr    = refResponse(phaseAddr, expData);
        mask      = laneMask(phaseSize, phaseAddr[1:0]);
        expCycles = (phaseAddr[31:28] == 4'h4) ? 3 : 1;
        checkCount++;
        if (expErr) begin
            if (!hresp || !errFirstSeen || phaseCycles != 2) begin
                errorCount++;
                $display("Transfer to 0x%08h ending at %0t was not a two-cycle ERROR response",
                         phaseAddr, $time);
            end
        end else if (hresp || errFirstSeen || phaseCycles != expCycles) begin
            errorCount++;
            $display("Transfer to 0x%08h ending at %0t took %0d cycles, expected %0d without error",
                     phaseAddr, $time, phaseCycles, expCycles);
        end else if (phaseWrite && phaseAddr[31:28] == 4'h0) begin
            shadow[phaseAddr[11:2]] = (shadow[phaseAddr[11:2]] & ~mask) | (hwdata & mask);
        end else if (!phaseWrite && ((hrdata & mask) !== (expData & mask))) begin
            errorCount++;
            $display("** Error at %0t: read of 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, phaseAddr, hrdata & mask, expData & mask);
        end
    endtask

    // ----------------------------------------------------------
    // Monitor, sampled on the rising edge
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!RSTn) begin
            active      = 1'b0;
            resetSeen   = 1'b0;
            errorCount  = 0;
            checkCount  = 0;
            testCount   = 0;
            startChecks = 0;
            startErrors = 0;
        end else begin
            if (!resetSeen) begin
                resetSeen = 1'b1;
                checkCount++;
                if (!hready || hresp || keyInt || $countones(~row) != 1) begin
                    errorCount++;
                    $display("** Error at %0t: after reset hready %b hresp %b keyInt %b row %b",
                             $time, hready, hresp, keyInt, row);
                end
            end
            if (active) begin
                phaseCycles++;
                if (hresp && !hready) begin
                    errFirstSeen = 1'b1;
                end
                if (hready) begin
                    finishPhase();
                    active = 1'b0;
                end
            end
            // New address phase
            if (hready && htrans == TransNonseq) begin
                active       = 1'b1;
                phaseAddr    = haddr;
                phaseWrite   = hwrite;
                phaseSize    = hsize;
                phaseCycles  = 0;
                errFirstSeen = 1'b0;
            end
            if (intProbe) begin
                checkCount++;
                if (keyInt !== intExpected) begin
                    errorCount++;
                    $display("** Error at %0t: keyInt is %b, expected %b",
                             $time, keyInt, intExpected);
                end
            end
            if (testDone) begin
                testCount++;
                $display("Test %0d %s: %0d checks, %0d errors", testNum, testName(testNum),
                         checkCount - startChecks, errorCount - startErrors);
                startChecks = checkCount;
                startErrors = errorCount;
            end
            if (runDone) begin
                $display("Summary: %0d tests, %0d checks, %0d errors",
                         testCount, checkCount, errorCount);
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tbTop.sv
`default_nettype none

module tbTop
    import tankPeriphPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RamDepth    = 1024;
    localparam int ScanDiv     = 8;
    localparam int ResetCycles = 10;
    localparam int WordCount   = 16;
    localparam int PairCount   = 8;
    localparam int SubRounds   = 4;
    localparam int ScanCycles  = 4 * ScanDiv;

    // Run length bound from transfers at 10 cycles each plus two keypad waits
    localparam int Transfers   = 2 * WordCount + 2 * PairCount + 4 * SubRounds + 4 + 3;
    localparam int LimitCycles = ResetCycles + 10 * Transfers + 2 * 3 * ScanCycles + 50;
    localparam int LimitNs     = 10 * LimitCycles;

    logic        clk = 1'b0;
    logic        RSTn;
    logic [31:0] haddr;
    htrans_e     htrans;
    logic        hwrite;
    hsize_e      hsize;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic [3:0]  col;
    logic [3:0]  row;
    logic        keyInt;
    logic        keyDown;
    logic [3:0]  keyIdx;
    logic        intProbe;
    logic        intExpected;
    logic        testDone;
    int          testNum;
    logic        runDone;
    int          errorCount;
    int          seed = 32'h5340;
    logic [31:0] wordAddrs [$];

    always #5 clk = ~clk;

    tankPeriphTop #(
        .RamWords   (RamDepth),
        .ScanDivide (ScanDiv)
    ) i_tankPeriphTop (
        .clk    (clk),
        .RSTn   (RSTn),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp),
        .col    (col),
        .row    (row),
        .keyInt (keyInt)
    );

    tbChecker #(
        .RamWords (RamDepth)
    ) i_tbChecker (
        .clk         (clk),
        .RSTn        (RSTn),
        .haddr       (haddr),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .hsize       (hsize),
        .hwdata      (hwdata),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp),
        .row         (row),
        .keyInt      (keyInt),
        .keyDown     (keyDown),
        .keyIdx      (keyIdx),
        .intProbe    (intProbe),
        .intExpected (intExpected),
        .testDone    (testDone),
        .testNum     (testNum),
        .runDone     (runDone),
        .errorCount  (errorCount)
    );

    // A held key ties its column to its row
    always_comb begin
        col = 4'hF;
        if (keyDown && !row[keyIdx[3:2]]) begin
            col[keyIdx[1:0]] = 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Bus tasks
    // ----------------------------------------------------------
    // Called on a falling edge
    // Address phase held until hready, then hwdata for its data phase
    task automatic issue(input logic [31:0] addr, input logic write,
                         input hsize_e size, input logic [31:0] wdata);
        haddr  = addr;
        htrans = TransNonseq;
        hwrite = write;
        hsize  = size;
        while (!hready) begin
            @(negedge clk);
        end
        @(negedge clk);
        htrans = TransIdle;
        if (write) begin
            hwdata = wdata;
        end
    endtask

    task automatic finishBus();
        while (!hready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic endTest(input int num);
        finishBus();
        testNum  = num;
        testDone = 1'b1;
        @(negedge clk);
        testDone = 1'b0;
    endtask

    task automatic probeInt(input logic expected);
        intExpected = expected;
        intProbe    = 1'b1;
        @(negedge clk);
        intProbe    = 1'b0;
    endtask

    function automatic logic [31:0] randRamAddr();
        logic [31:0] r;
        r = $random(seed);
        return {20'h0, r[9:0], 2'b00};
    endfunction

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        logic [31:0] a;
        logic [31:0] w;
        logic [1:0]  off;
        RSTn        = 1'b0;
        haddr       = '0;
        htrans      = TransIdle;
        hwrite      = 1'b0;
        hsize       = SizeWord;
        hwdata      = '0;
        keyDown     = 1'b0;
        keyIdx      = 4'd0;
        intProbe    = 1'b0;
        intExpected = 1'b0;
        testDone    = 1'b0;
        testNum     = 0;
        runDone     = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        RSTn = 1'b1;
        endTest(1);

        for (int i = 0; i < WordCount; i++) begin
            a = randRamAddr();
            w = $random(seed);
            wordAddrs.push_back(a);
            issue(a, 1'b1, SizeWord, w);
        end
        foreach (wordAddrs[i]) begin
            issue(wordAddrs[i], 1'b0, SizeWord, 32'h0);
        end
        // Read straight behind a write of the same word
        for (int i = 0; i < PairCount; i++) begin
            a = randRamAddr();
            w = $random(seed);
            issue(a, 1'b1, SizeWord, w);
            issue(a, 1'b0, SizeWord, 32'h0);
        end
        endTest(2);

        for (int i = 0; i < SubRounds; i++) begin
            a   = randRamAddr();
            off = 2'(i);
            w   = $random(seed);
            issue(a, 1'b1, SizeWord, w);
            w = $random(seed);
            issue({a[31:2], off}, 1'b1, SizeByte, w);
            issue({a[31:2], ~off[1], 1'b0}, 1'b1, SizeHalf, ~w);
            issue(a, 1'b0, SizeWord, 32'h0);
        end
        endTest(3);

        issue(32'h8000_0000, 1'b0, SizeWord, 32'h0);
        issue(wordAddrs[0], 1'b0, SizeWord, 32'h0);
        issue(32'h4000_3000, 1'b0, SizeWord, 32'h0);
        issue(wordAddrs[1], 1'b0, SizeWord, 32'h0);
        endTest(4);

        w       = $random(seed);
        keyIdx  = w[3:0];
        keyDown = 1'b1;
        repeat (3 * ScanCycles) @(negedge clk);
        probeInt(1'b1);
        issue(32'h4000_0000, 1'b0, SizeWord, 32'h0);
        endTest(5);

        issue(32'h4000_0004, 1'b1, SizeWord, 32'h1);
        finishBus();
        probeInt(1'b0);
        keyDown = 1'b0;
        repeat (3 * ScanCycles) @(negedge clk);
        issue(32'h4000_0000, 1'b0, SizeWord, 32'h0);
        finishBus();
        probeInt(1'b0);
        endTest(6);

        runDone = 1'b1;
        @(negedge clk);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LimitNs);
        $display("Watchdog expired after %0d ns, the run did not complete", LimitNs);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/tankPeriphPkg.sv
rtl/ahbDecode.sv
rtl/blockRam.sv
rtl/apbBridge.sv
rtl/keypadScanner.sv
rtl/responseMerge.sv
rtl/tankPeriphTop.sv
bench/tbChecker.sv
bench/tbTop.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tbTop -o tbTop

out=$(./obj_dir/tbTop)
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"
